// File: hw/bus_pkg.sv
/*
 Z80 port and DRAM bus types used by the port decoder,
 the DMA engine and the top level
*/
package bus_pkg;

	typedef logic [7:0]  zbyte_t;      // Z80 data byte
	typedef logic [7:0]  port_addr_t;  // Z80 I/O port address
	typedef logic [15:0] word_t;       // DRAM or IDE word
	typedef logic [20:0] dram_addr_t;  // DRAM word address

	// one Z80 port write, wr is a single-cycle pulse
	typedef struct packed {
		port_addr_t addr;
		zbyte_t     data;
		logic       wr;
	} port_wr_t;

	// DRAM request, req holds until dram_next
	typedef struct packed {
		dram_addr_t addr;
		word_t      wrdata;
		logic       req;
		logic       rnw;
	} dram_req_t;

endpackage

// File: hw/dma_pkg.sv
/*
 DMA control types, device codes, register strobe layout
 and the engine phase encoding
*/
package dma_pkg;

	typedef logic [2:0] dev_t;

	localparam dev_t DEV_RAM = 3'b001;
	localparam dev_t DEV_SD  = 3'b010;
	localparam dev_t DEV_IDE = 3'b011;

	// control byte bits 7, 6 and 2:0
	typedef struct packed {
		logic wnr;    // 1 = RAM to device
		logic zwait;  // hold the Z80 while the burst runs
		dev_t device;
	} dma_ctrl_t;

	// one strobe per register port, offset from the base port
	typedef logic [8:0] reg_stb_t;

	localparam int STB_SADDR_L = 0;
	localparam int STB_SADDR_H = 1;
	localparam int STB_SADDR_X = 2;
	localparam int STB_DADDR_L = 3;
	localparam int STB_DADDR_H = 4;
	localparam int STB_DADDR_X = 5;
	localparam int STB_LEN     = 6;
	localparam int STB_LAUNCH  = 7;
	localparam int STB_NUM     = 8;  // last port of the block

	typedef enum logic {
		PH_RD = 1'b0,
		PH_WR = 1'b1
	} phase_t;

endpackage

// File: hw/dma_regs.sv
/*
 DMA port decoder: turns Z80 port writes into register strobes,
 blocks them during a burst and holds launch until a refresh cycle
*/
`timescale 1ns/1ns

module dma_regs
	import bus_pkg::*;
	import dma_pkg::*;
#(
	parameter port_addr_t DMA_PORT_BASE = 8'h1a
)
(
	input  logic     clk,
	input  logic     rst_n,
	input  port_wr_t port_wr,
	input  logic     rfsh_n,
	input  logic     dma_act,
	output reg_stb_t stb,
	output zbyte_t   wdata
);

	port_addr_t ofs;
	reg_stb_t   dec;
	logic       launch_en;  // refresh seen since the last burst began
	logic       act_q;

	assign ofs   = port_wr.addr - DMA_PORT_BASE;
	assign wdata = port_wr.data;

	// port offset to one-hot strobe
	always_comb
	begin
		dec = '0;
		if (port_wr.wr && ofs <= port_addr_t'(STB_NUM))
			dec[ofs[3:0]] = 1'b1;
	end

	always_comb
	begin
		stb = dec & {9{!dma_act}};  // no register writes mid-burst
		stb[STB_LAUNCH] = dec[STB_LAUNCH] & !dma_act & launch_en;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			act_q     <= 1'b0;
			launch_en <= 1'b1;
		end
		else
		begin
			act_q <= dma_act;
			if (!rfsh_n)
				launch_en <= 1'b1;
			else if (dma_act && !act_q)
				launch_en <= 1'b0;  // burst just started
		end
	end

	a_stb_onehot: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0(stb)
	) else $error("dma_regs: more than one register strobe");

endmodule

// File: hw/dma_engine.sv
/*
 DMA burst engine: read and write phases per word, data latch,
 word counter and the DRAM source and destination counters
*/
`timescale 1ns/1ns

module dma_engine
	import bus_pkg::*;
	import dma_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      c2,
	input  reg_stb_t  stb,
	input  zbyte_t    wdata,
	output dram_req_t dram,
	input  word_t     dram_rddata,
	input  logic      dram_next,
	input  word_t     dev_rddata,
	input  logic      dev_stb,
	output logic      dev_req,
	output logic      dev_rnw,
	output word_t     dev_wrdata,
	output dev_t      device,
	output logic      dma_act,
	output logic      dma_wait
);

	dram_addr_t s_addr;
	dram_addr_t d_addr;
	zbyte_t     b_len;
	logic [8:0] ctr;    // top bit set when idle
	dma_ctrl_t  ctrl;
	phase_t     phase;
	word_t      data;

	logic launch;
	logic dv_ram;
	logic rd;
	logic state_mem;
	logic state_dev;
	logic mem_req;
	logic phase_end;
	logic cyc_end;

	assign launch   = stb[STB_LAUNCH] & c2;
	assign dma_act  = ~ctr[8];
	assign dma_wait = dma_act & ctrl.zwait;

	// which side each phase serves
	//   RAM-RAM        memory in both phases
	//   device to RAM  device reads, memory writes
	//   RAM to device  memory reads, device writes
	assign dv_ram    = ctrl.device == DEV_RAM;
	assign rd        = phase == PH_RD;
	assign state_mem = dv_ram | (ctrl.wnr ^ !rd);
	assign state_dev = !dv_ram & (ctrl.wnr ^ rd);

	assign mem_req   = dma_act & state_mem;
	assign dev_req   = dma_act & state_dev;
	assign phase_end = (mem_req & dram_next) | (dev_req & dev_stb);
	assign cyc_end   = !rd & phase_end;  // word done

	assign dram = '{
		addr:   rd ? s_addr : d_addr,
		wrdata: data,
		req:    mem_req,
		rnw:    rd
	};

	assign dev_rnw    = rd;
	assign dev_wrdata = data;
	assign device     = ctrl.device;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			ctr   <= 9'h100;
			ctrl  <= '0;
			phase <= PH_RD;
		end
		else if (launch)
		begin
			ctr   <= {1'b0, b_len};  // len+1 words
			ctrl  <= dma_ctrl_t'({wdata[7], wdata[6], wdata[2:0]});
			phase <= PH_RD;
		end
		else if (phase_end)
		begin
			phase <= rd ? PH_WR : PH_RD;
			if (cyc_end)
				ctr <= ctr - 1'b1;  // wraps to idle after the last word
		end
	end

	// address and length registers
	always_ff @(posedge clk)
	begin
		if (stb[STB_LEN])
			b_len <= wdata;
		if (stb[STB_SADDR_L])
			s_addr[6:0] <= wdata[7:1];  // bit 0 of the byte address dropped
		if (stb[STB_SADDR_H])
			s_addr[12:7] <= wdata[5:0];
		if (stb[STB_SADDR_X])
			s_addr[20:13] <= wdata;
		if (stb[STB_DADDR_L])
			d_addr[6:0] <= wdata[7:1];
		if (stb[STB_DADDR_H])
			d_addr[12:7] <= wdata[5:0];
		if (stb[STB_DADDR_X])
			d_addr[20:13] <= wdata;

		if (mem_req && dram_next)
		begin
			if (rd)
				s_addr <= s_addr + 1'b1;
			else
				d_addr <= d_addr + 1'b1;
		end
	end

	// data latch, filled in the read phase
	always_ff @(posedge clk)
	begin
		if (rd && mem_req && dram_next)
			data <= dram_rddata;
		else if (rd && dev_req && dev_stb)
			data <= dev_rddata;
	end

	a_req_excl: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(dram.req && dev_req)
	) else $error("dma_engine: DRAM and device requested together");

	a_phase_idle: assert property (
		@(posedge clk) disable iff (!rst_n)
		!dma_act |=> $stable(phase)
	) else $error("dma_engine: phase moved while idle");

endmodule

// File: hw/dev_mux.sv
/*
 Device steering: routes the engine request to SD or IDE,
 packs SD bytes into words and forms the device word strobe
*/
`timescale 1ns/1ns

module dev_mux
	import bus_pkg::*;
	import dma_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   dev_req,
	input  logic   dev_rnw,
	input  word_t  dev_wrdata,
	input  dev_t   device,
	output word_t  dev_rddata,
	output logic   dev_stb,
	output logic   sd_req,
	output logic   sd_rnw,
	output zbyte_t sd_wrdata,
	input  zbyte_t sd_rddata,
	input  logic   sd_stb,
	output logic   ide_req,
	output logic   ide_rnw,
	output word_t  ide_wrdata,
	input  word_t  ide_rddata,
	input  logic   ide_stb
);

	logic   dv_sd;
	logic   bsel;     // 0 = low byte next
	logic   sd_done;
	zbyte_t lo_byte;

	assign dv_sd   = device == DEV_SD;
	assign sd_req  = dev_req & dv_sd;
	assign ide_req = dev_req & (device == DEV_IDE);
	assign sd_rnw  = dev_rnw;
	assign ide_rnw = dev_rnw;
	assign sd_done = sd_req & sd_stb;

	assign sd_wrdata  = bsel ? dev_wrdata[15:8] : dev_wrdata[7:0];
	assign ide_wrdata = dev_wrdata;

	// high byte comes straight off the bus with the second strobe
	assign dev_rddata = dv_sd ? {sd_rddata, lo_byte} : ide_rddata;
	assign dev_stb    = (sd_done & bsel) | (ide_req & ide_stb);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			bsel <= 1'b0;
		else if (sd_done)
			bsel <= ~bsel;
	end

	always_ff @(posedge clk)
	begin
		if (sd_done && !bsel)
			lo_byte <= sd_rddata;
	end

	a_dev_excl: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(sd_req && ide_req)
	) else $error("dev_mux: SD and IDE requested together");

endmodule

// File: hw/dma_top.sv
/*
 Burst DMA top: port decoder, engine and device steering
*/
`timescale 1ns/1ns

module dma_top
	import bus_pkg::*;
	import dma_pkg::*;
#(
	parameter port_addr_t DMA_PORT_BASE = 8'h1a  // DMASAddrL
)
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      c2,
	input  logic      rfsh_n,
	input  port_wr_t  port_wr,
	output dram_req_t dram,
	input  word_t     dram_rddata,
	input  logic      dram_next,
	output logic      sd_req,
	output logic      sd_rnw,
	output zbyte_t    sd_wrdata,
	input  zbyte_t    sd_rddata,
	input  logic      sd_stb,
	output logic      ide_req,
	output logic      ide_rnw,
	output word_t     ide_wrdata,
	input  word_t     ide_rddata,
	input  logic      ide_stb,
	output logic      dma_act,
	output logic      dma_wait
);

	reg_stb_t stb;
	zbyte_t   wdata;
	word_t    dev_rddata;
	word_t    dev_wrdata;
	logic     dev_stb;
	logic     dev_req;
	logic     dev_rnw;
	dev_t     device;

	dma_regs #(
		.DMA_PORT_BASE (DMA_PORT_BASE)
	) u_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.port_wr (port_wr),
		.rfsh_n  (rfsh_n),
		.dma_act (dma_act),
		.stb     (stb),
		.wdata   (wdata)
	);

	dma_engine u_engine (
		.clk         (clk),
		.rst_n       (rst_n),
		.c2          (c2),
		.stb         (stb),
		.wdata       (wdata),
		.dram        (dram),
		.dram_rddata (dram_rddata),
		.dram_next   (dram_next),
		.dev_rddata  (dev_rddata),
		.dev_stb     (dev_stb),
		.dev_req     (dev_req),
		.dev_rnw     (dev_rnw),
		.dev_wrdata  (dev_wrdata),
		.device      (device),
		.dma_act     (dma_act),
		.dma_wait    (dma_wait)
	);

	dev_mux u_dev (
		.clk        (clk),
		.rst_n      (rst_n),
		.dev_req    (dev_req),
		.dev_rnw    (dev_rnw),
		.dev_wrdata (dev_wrdata),
		.device     (device),
		.dev_rddata (dev_rddata),
		.dev_stb    (dev_stb),
		.sd_req     (sd_req),
		.sd_rnw     (sd_rnw),
		.sd_wrdata  (sd_wrdata),
		.sd_rddata  (sd_rddata),
		.sd_stb     (sd_stb),
		.ide_req    (ide_req),
		.ide_rnw    (ide_rnw),
		.ide_wrdata (ide_wrdata),
		.ide_rddata (ide_rddata),
		.ide_stb    (ide_stb)
	);

endmodule

// File: bench/tb_mem_dev.sv
/*
 Bus models for the DMA testbench: DRAM that answers on c2,
 SD byte device and IDE word sink, all with random latency
*/
`timescale 1ns/1ns

module tb_mem_dev
	import bus_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	output logic      c2,
	input  dram_req_t dram,
	output word_t     dram_rddata,
	output logic      dram_next,
	input  logic      sd_req,
	input  logic      sd_rnw,
	input  zbyte_t    sd_wrdata,
	output zbyte_t    sd_rddata,
	output logic      sd_stb,
	input  logic      ide_req,
	input  logic      ide_rnw,
	input  word_t     ide_wrdata,
	output word_t     ide_rddata,
	output logic      ide_stb
);

	word_t  mem [0:1023];
	zbyte_t sd_src [0:63];   // filled by the testbench
	int     sd_i;
	int     dram_dly;
	int     sd_dly;
	int     ide_dly;

	initial
	begin
		for (int i = 0; i < 1024; i++)
			mem[i] = word_t'(i * 40503) ^ 16'ha5c3;  // every address bit counts
		c2          = 1'b0;
		dram_next   = 1'b0;
		sd_stb      = 1'b0;
		ide_stb     = 1'b0;
		dram_rddata = '0;
		sd_rddata   = '0;
		ide_rddata  = '0;
		sd_i        = 0;
		dram_dly    = 0;
		sd_dly      = 0;
		ide_dly     = 0;
	end

	// DRAM answers only in a cycle where c2 is high
	always @(posedge clk)
	begin
		#1;
		c2 <= ~c2;
		dram_next <= 1'b0;
		if (rst_n && dram.req && !dram_next)
		begin
			if (dram_dly > 0)
				dram_dly = dram_dly - 1;
			else if (!c2)
			begin
				dram_next   <= 1'b1;
				dram_rddata <= mem[dram.addr[9:0]];
				dram_dly = $urandom % 4;
			end
		end
	end

	always @(posedge clk)
	begin
		#1;
		sd_stb <= 1'b0;
		if (rst_n && sd_req && !sd_stb)
		begin
			if (sd_dly > 0)
				sd_dly = sd_dly - 1;
			else
			begin
				sd_stb    <= 1'b1;
				sd_rddata <= sd_src[sd_i];
				sd_dly = $urandom % 4;
			end
		end
	end

	always @(posedge clk)
	begin
		#1;
		ide_stb <= 1'b0;
		if (rst_n && ide_req && !ide_stb)
		begin
			if (ide_dly > 0)
				ide_dly = ide_dly - 1;
			else
			begin
				ide_stb <= 1'b1;
				ide_dly = $urandom % 4;
			end
		end
	end

	// transfers complete on the edge that sees the strobe
	always @(posedge clk)
	begin
		if (dram.req && !dram.rnw && dram_next)
			mem[dram.addr[9:0]] <= dram.wrdata;
		if (sd_req && sd_rnw && sd_stb)
			sd_i <= sd_i + 1;
	end

endmodule

// File: bench/tb_dma.sv
/*
 Testbench for the burst DMA: Z80 port writes, bus models
 and assertions on every DRAM, SD and IDE write
*/
`timescale 1ns/1ns

module tb_dma
	import bus_pkg::*;
	import dma_pkg::*;
;

	localparam port_addr_t BASE  = 8'h1a;
	localparam int         WORDS = 8 + 4 + 5 + 2 + 4 + 4 + 2;

	logic      clk;
	logic      rst_n;
	logic      c2;
	logic      rfsh_n;
	port_wr_t  port_wr;
	dram_req_t dram;
	word_t     dram_rddata;
	logic      dram_next;
	logic      sd_req;
	logic      sd_rnw;
	zbyte_t    sd_wrdata;
	zbyte_t    sd_rddata;
	logic      sd_stb;
	logic      ide_req;
	logic      ide_rnw;
	word_t     ide_wrdata;
	word_t     ide_rddata;
	logic      ide_stb;
	logic      dma_act;
	logic      dma_wait;

	word_t      dram_exp_d [0:63];  // expected DRAM writes in order
	dram_addr_t dram_exp_a [0:63];
	word_t      ide_exp [0:15];
	zbyte_t     sd_exp [0:15];      // expected SD bytes in order
	int         dram_n;
	int         dram_i;
	int         ide_en;
	int         ide_i;
	int         sd_en;
	int         sd_i;
	logic       launched;
	logic       zwait_on;
	logic       dram_wr;
	logic       ide_wr;
	logic       sd_wr;

	dma_top #(
		.DMA_PORT_BASE (BASE)
	) u_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.c2          (c2),
		.rfsh_n      (rfsh_n),
		.port_wr     (port_wr),
		.dram        (dram),
		.dram_rddata (dram_rddata),
		.dram_next   (dram_next),
		.sd_req      (sd_req),
		.sd_rnw      (sd_rnw),
		.sd_wrdata   (sd_wrdata),
		.sd_rddata   (sd_rddata),
		.sd_stb      (sd_stb),
		.ide_req     (ide_req),
		.ide_rnw     (ide_rnw),
		.ide_wrdata  (ide_wrdata),
		.ide_rddata  (ide_rddata),
		.ide_stb     (ide_stb),
		.dma_act     (dma_act),
		.dma_wait    (dma_wait)
	);

	tb_mem_dev u_models (
		.clk         (clk),
		.rst_n       (rst_n),
		.c2          (c2),
		.dram        (dram),
		.dram_rddata (dram_rddata),
		.dram_next   (dram_next),
		.sd_req      (sd_req),
		.sd_rnw      (sd_rnw),
		.sd_wrdata   (sd_wrdata),
		.sd_rddata   (sd_rddata),
		.sd_stb      (sd_stb),
		.ide_req     (ide_req),
		.ide_rnw     (ide_rnw),
		.ide_wrdata  (ide_wrdata),
		.ide_rddata  (ide_rddata),
		.ide_stb     (ide_stb)
	);

	assign dram_wr = dram.req && !dram.rnw && dram_next;
	assign ide_wr  = ide_req && !ide_rnw && ide_stb;
	assign sd_wr   = sd_req && !sd_rnw && sd_stb;

	task automatic fail_msg(input string what);
		$display("FAIL at %0t: %s", $time, what);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("FAIL at %0t: %s got %h expected %h", $time, name, got, exp);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial
	begin
		#((WORDS * 64 + 2000) * 8);
		fail_msg("watchdog timeout, a burst never finished");
	end

	always @(posedge clk)
	begin
		if (dram_wr)
			dram_i <= dram_i + 1;
		if (ide_wr)
			ide_i <= ide_i + 1;
		if (sd_wr)
			sd_i <= sd_i + 1;
	end

	a_dram_cnt: assert property (@(posedge clk) disable iff (!rst_n)
		dram_wr |-> dram_i < dram_n
	) else fail_msg("more DRAM writes than expected");

	a_dram_addr: assert property (@(posedge clk) disable iff (!rst_n)
		dram_wr |-> dram.addr == dram_exp_a[dram_i]
	) else fail_value("dram.addr", $sampled(dram.addr), dram_exp_a[$sampled(dram_i)]);

	a_dram_data: assert property (@(posedge clk) disable iff (!rst_n)
		dram_wr |-> dram.wrdata == dram_exp_d[dram_i]
	) else fail_value("dram.wrdata", $sampled(dram.wrdata), dram_exp_d[$sampled(dram_i)]);

	a_ide_cnt: assert property (@(posedge clk) disable iff (!rst_n)
		ide_wr |-> ide_i < ide_en
	) else fail_msg("more IDE writes than expected");

	a_ide_data: assert property (@(posedge clk) disable iff (!rst_n)
		ide_wr |-> ide_wrdata == ide_exp[ide_i]
	) else fail_value("ide_wrdata", $sampled(ide_wrdata), ide_exp[$sampled(ide_i)]);

	a_sd_cnt: assert property (@(posedge clk) disable iff (!rst_n)
		sd_wr |-> sd_i < sd_en
	) else fail_msg("more SD writes than expected");

	a_sd_data: assert property (@(posedge clk) disable iff (!rst_n)
		sd_wr |-> sd_wrdata == sd_exp[sd_i]
	) else fail_value("sd_wrdata", $sampled(sd_wrdata), sd_exp[$sampled(sd_i)]);

	a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!launched |-> !(dma_act || dma_wait || dram.req || sd_req || ide_req)
	) else fail_msg("DMA outputs active before the first launch");

	a_wait: assert property (@(posedge clk) disable iff (!rst_n)
		dma_wait == (dma_act && zwait_on)
	) else fail_value("dma_wait", $sampled(dma_wait), $sampled(dma_act && zwait_on));

	task automatic port_write(input int ofs, input zbyte_t d);
		@(posedge clk);
		#1;
		port_wr = '{addr: BASE + port_addr_t'(ofs), data: d, wr: 1'b1};
		@(posedge clk);
		#1;
		port_wr.wr = 1'b0;
	endtask

	// byte address registers, word address shifted up by one
	task automatic set_burst(input dram_addr_t s, input dram_addr_t d, input zbyte_t len);
		port_write(STB_SADDR_L, {s[6:0], 1'b0});
		port_write(STB_SADDR_H, {2'b00, s[12:7]});
		port_write(STB_SADDR_X, s[20:13]);
		port_write(STB_DADDR_L, {d[6:0], 1'b0});
		port_write(STB_DADDR_H, {2'b00, d[12:7]});
		port_write(STB_DADDR_X, d[20:13]);
		port_write(STB_LEN, len);
	endtask

	// launch write placed in a cycle with c2 high
	task automatic launch(input zbyte_t ctrl);
		do
		begin
			@(posedge clk);
			#1;
		end
		while (c2);  // old value, flips high this cycle
		port_wr  = '{addr: BASE + port_addr_t'(STB_LAUNCH), data: ctrl, wr: 1'b1};
		launched = 1'b1;
		@(posedge clk);
		#1;
		port_wr.wr = 1'b0;
	endtask

	task automatic wait_idle();
		while (dma_act)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic refresh_pulse();
		@(posedge clk);
		#1;
		rfsh_n = 1'b0;
		@(posedge clk);
		#1;
		rfsh_n = 1'b1;
	endtask

	task automatic expect_copy(input dram_addr_t s, input dram_addr_t d, input int n);
		for (int k = 0; k < n; k++)
		begin
			dram_exp_a[dram_n] = d + dram_addr_t'(k);
			dram_exp_d[dram_n] = u_models.mem[10'(s + dram_addr_t'(k))];
			dram_n = dram_n + 1;
		end
	endtask

	task automatic check_counts();
		if (dram_i != dram_n)
			fail_value("dram write count", dram_i, dram_n);
		if (ide_i != ide_en)
			fail_value("ide write count", ide_i, ide_en);
		if (sd_i != sd_en)
			fail_value("sd write count", sd_i, sd_en);
	endtask

	initial
	begin
		void'($urandom(32'h0c8b_612d));
		rst_n    = 1'b0;
		rfsh_n   = 1'b1;
		port_wr  = '0;
		launched = 1'b0;
		zwait_on = 1'b0;
		dram_n   = 0;
		dram_i   = 0;
		ide_en   = 0;
		ide_i    = 0;
		sd_en    = 0;
		sd_i     = 0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		repeat (20) @(posedge clk);  // idle outputs watched by a_quiet

		// RAM to RAM, 8 words
		set_burst(21'h010, 21'h040, 8'd7);
		expect_copy(21'h010, 21'h040, 8);
		launch(8'h01);
		wait_idle();
		check_counts();

		// SD to RAM, low byte first
		for (int k = 0; k < 8; k++)
			u_models.sd_src[k] = zbyte_t'($urandom);
		for (int k = 0; k < 4; k++)
		begin
			dram_exp_a[dram_n] = 21'h0a0 + dram_addr_t'(k);
			dram_exp_d[dram_n] = {u_models.sd_src[2 * k + 1], u_models.sd_src[2 * k]};
			dram_n = dram_n + 1;
		end
		set_burst(21'h000, 21'h0a0, 8'd3);
		refresh_pulse();
		launch(8'h02);
		wait_idle();
		check_counts();

		// RAM to IDE, 5 words
		for (int k = 0; k < 5; k++)
			ide_exp[k] = u_models.mem[10'(21'h060 + k)];
		ide_en = 5;
		set_burst(21'h060, 21'h000, 8'd4);
		refresh_pulse();
		launch(8'h83);
		wait_idle();
		check_counts();

		// RAM to SD, low byte first
		for (int k = 0; k < 2; k++)
		begin
			sd_exp[2 * k]     = u_models.mem[10'(21'h0c0 + k)][7:0];
			sd_exp[2 * k + 1] = u_models.mem[10'(21'h0c0 + k)][15:8];
		end
		sd_en = 4;
		set_burst(21'h0c0, 21'h000, 8'd1);
		refresh_pulse();
		launch(8'h82);
		wait_idle();
		check_counts();

		// register writes during a burst are dropped
		set_burst(21'h100, 21'h200, 8'd3);
		expect_copy(21'h100, 21'h200, 4);
		refresh_pulse();
		launch(8'h01);
		port_write(STB_DADDR_L, 8'h80);
		port_write(STB_LEN, 8'h0f);
		wait_idle();
		check_counts();
		expect_copy(21'h104, 21'h204, 4);  // counters carry on
		refresh_pulse();
		launch(8'h01);
		wait_idle();
		check_counts();

		// no refresh since the last burst, so no start
		launch(8'h01);
		repeat (10)
		begin
			@(posedge clk);
			#1;
			if (dma_act)
				fail_msg("burst started without a refresh cycle");
		end
		set_burst(21'h300, 21'h380, 8'd1);
		expect_copy(21'h300, 21'h380, 2);
		refresh_pulse();
		zwait_on = 1'b1;
		launch(8'h41);
		wait_idle();
		zwait_on = 1'b0;
		check_counts();

		repeat (5) @(posedge clk);
		$display("=== PASS ===");
		$finish;
	end

endmodule

// File: vlog.f
hw/bus_pkg.sv
hw/dma_pkg.sv
hw/dma_regs.sv
hw/dma_engine.sv
hw/dev_mux.sv
hw/dma_top.sv
bench/tb_mem_dev.sv
bench/tb_dma.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --assert --timing -Wno-fatal
TOP      = tb_dma
FILELIST = vlog.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)
